// File: video_blend.f
video_pkg.sv
blend_pkg.sv
blend_decode.sv
blend_execute.sv
blend_result.sv
video_blend.sv
tb_video_blend.sv

// File: Bender.yml
package:
  name: video_blend

sources:
  - video_pkg.sv
  - blend_pkg.sv
  - blend_decode.sv
  - blend_execute.sv
  - blend_result.sv
  - video_blend.sv
  - target: simulation
    files:
      - tb_video_blend.sv

// File: tb_video_blend.sv
/* pixel blender testbench */

`timescale 1ns/1ps

module tb_video_blend;

    import video_pkg::*;
    import blend_pkg::*;

    localparam int RST_CYCLES = 8;
    localparam int STREAM_N   = 500;
    localparam int MAX_CYCLES = 2000;       // about 650 cycles of tests and 3x margin

    logic        clk;
    logic        arst_n_i;
    logic        vsync_i;
    logic        hsync_i;
    logic        de_i;
    argb_t       color_a_i;
    argb_t       color_b_i;
    rgb_t        rgb_o;
    logic        vsync_o;
    logic        hsync_o;
    logic        de_o;

    logic [31:0] rng_state;
    int          cycles;                    // cycle count for the timeout
    int          slot;                      // index of the pixel last driven
    int          err_cnt;
    int          test_err;                  // err_cnt when the test began
    int          pass_cnt;
    int          fail_cnt;
    string       cur_test;
    rgb_t        exp_rgb_q[$];              // model output in arrival order
    logic [2:0]  exp_sync_q[$];             // {vsync, hsync, de}
    int          due_q[$];                  // slot at which each entry shows

    video_blend dut0 (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .vsync_i   (vsync_i),
        .hsync_i   (hsync_i),
        .de_i      (de_i),
        .color_a_i (color_a_i),
        .color_b_i (color_b_i),
        .rgb_o     (rgb_o),
        .vsync_o   (vsync_o),
        .hsync_o   (hsync_o),
        .de_o      (de_o)
    );

    always #4 clk = ~clk;                   // 8 ns period

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("simulation timed out after %0d cycles", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic argb_t rand_argb();
        logic [31:0] r;
        r = xorshift32();
        return argb_t'(r[15:0]);
    endfunction

    // expected pixel from integer arithmetic on the blend rule
    function automatic rgb_t blend_model(input argb_t a, input argb_t b, input logic de);
        int   wa;
        int   wb;
        int   ca[3];
        int   cb[3];
        int   s;
        int   nib[3];
        logic clamp;
        ca = '{a.r * 17, a.g * 17, a.b * 17}; // nibble repeated = x17
        cb = '{b.r * 17, b.g * 17, b.b * 17};
        wb = b.a * 17;
        wa = 255;
        case (a.a[3:2])
            2'd0:    wa = (15 - b.a) * 17;  // inverse of b alpha
            2'd3:    wb = 0;                // b ignored
            default: wa = 255;
        endcase
        clamp = a.a[3];
        for (int i = 0; i < 3; i++) begin
            s = (ca[i] * wa) / 512 + (cb[i] * wb) / 512;
            nib[i] = (clamp && s >= 128) ? 15 : (s / 8) % 16;
        end
        if (!de) begin
            return '0;                      // blanked
        end
        return rgb_t'({nib[0][3:0], nib[1][3:0], nib[2][3:0]});
    endfunction

    task automatic check_rgb(input rgb_t expected);
        if (rgb_o !== expected) begin
            $display("FAIL %s rgb expected %h actual %h", cur_test, expected, rgb_o);
            err_cnt++;
        end
    endtask

    task automatic check_sync(input logic exp_vs, input logic exp_hs, input logic exp_de);
        if ({vsync_o, hsync_o, de_o} !== {exp_vs, exp_hs, exp_de}) begin
            $display("FAIL %s vsync/hsync/de expected %b%b%b actual %b%b%b", cur_test,
                     exp_vs, exp_hs, exp_de, vsync_o, hsync_o, de_o);
            err_cnt++;
        end
    endtask

    // drive one pixel and check whatever is due at the negedge
    task automatic drive_pixel(input argb_t a, input argb_t b, input logic de,
                               input logic hs, input logic vs, input bit track);
        logic [2:0] sync;
        @(posedge clk);
        color_a_i <= a;
        color_b_i <= b;
        de_i      <= de;
        hsync_i   <= hs;
        vsync_i   <= vs;
        slot++;
        if (track) begin
            exp_rgb_q.push_back(blend_model(a, b, de));
            exp_sync_q.push_back({vs, hs, de});
            due_q.push_back(slot + 3);      // three register stages
        end
        @(negedge clk);
        if (due_q.size() > 0 && due_q[0] == slot) begin
            check_rgb(exp_rgb_q.pop_front());
            sync = exp_sync_q.pop_front();
            check_sync(sync[2], sync[1], sync[0]);
            void'(due_q.pop_front());
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_err = err_cnt;
    endtask

    task automatic end_test();
        repeat (3) drive_pixel('0, '0, 1'b0, 1'b0, 1'b0, 1'b0); // flush pipeline
        if (due_q.size() != 0) begin
            $display("%s left %0d expected pixels unchecked", cur_test, due_q.size());
            err_cnt++;
        end
        if (err_cnt == test_err) begin
            pass_cnt++;
            $display("%s: ok", cur_test);
        end else begin
            fail_cnt++;
            $display("%s: %0d mismatches", cur_test, err_cnt - test_err);
        end
    endtask

    task automatic reset_state();
        begin_test("reset");
        repeat (RST_CYCLES) begin
            @(negedge clk);
            check_rgb('0);
            check_sync(1'b0, 1'b0, 1'b0);
        end
        @(posedge clk);
        arst_n_i <= 1'b1;
        repeat (3) begin                    // idle inputs keep outputs black
            @(negedge clk);
            check_rgb('0);
            check_sync(1'b0, 1'b0, 1'b0);
        end
        end_test();
    endtask

    task automatic opaque_ignores_b();
        argb_t a;
        begin_test("opaque");
        for (int i = 0; i < 20; i++) begin
            a = rand_argb();
            a.a[3:2] = MODE_OPAQUE;
            repeat (2) drive_pixel(a, rand_argb(), 1'b1, 1'b0, 1'b0, 1'b1); // B varies
        end
        end_test();
    endtask

    task automatic blend_by_alpha();
        nibble_t alphas[3];
        argb_t   a;
        argb_t   b;
        alphas = '{4'h0, 4'h8, 4'hF};
        begin_test("blend");
        foreach (alphas[k]) begin
            for (int i = 0; i < 12; i++) begin
                a = rand_argb();
                a.a[3:2] = MODE_BLEND;
                b = rand_argb();
                b.a = alphas[k];
                drive_pixel(a, b, 1'b1, 1'b0, 1'b0, 1'b1);
            end
        end
        end_test();
    endtask

    task automatic wrap_vs_clamp();
        argb_t a;
        argb_t b;
        begin_test("wrap_clamp");
        a = {4'h0, 4'h8, 4'h8, 4'h8};       // sum 134 sets bit 7
        b = {4'hF, 4'h8, 4'h8, 4'h8};
        a.a[3:2] = MODE_ADD_WRAP;
        drive_pixel(a, b, 1'b1, 1'b0, 1'b0, 1'b1); // bits 6..3 give 0
        a.a[3:2] = MODE_ADD_CLAMP;
        drive_pixel(a, b, 1'b1, 1'b0, 1'b0, 1'b1); // pinned at 15
        for (int i = 0; i < 8; i++) begin
            a = rand_argb() | 16'h0CCC;     // bright colours
            b = rand_argb() | 16'hCCCC;     // high alpha, sum at least 182
            a.a[3:2] = MODE_ADD_WRAP;
            drive_pixel(a, b, 1'b1, 1'b0, 1'b0, 1'b1);
            a.a[3:2] = MODE_ADD_CLAMP;
            drive_pixel(a, b, 1'b1, 1'b0, 1'b0, 1'b1);
        end
        end_test();
    endtask

    task automatic sync_and_blanking();
        begin_test("sync_blank");
        for (int i = 0; i < 24; i++) begin
            drive_pixel(rand_argb(), rand_argb(), (i % 5) != 0, (i % 7) < 2,
                        ((i / 8) % 2) == 1, 1'b1);
        end
        end_test();
    endtask

    task automatic random_stream();
        logic [31:0] r;
        begin_test("stream");
        for (int i = 0; i < STREAM_N; i++) begin
            r = xorshift32();
            drive_pixel(rand_argb(), rand_argb(), 1'b1, r[0], r[1], 1'b1);
        end
        end_test();
    endtask

    initial begin
        clk       = 1'b0;
        arst_n_i  = 1'b1;
        vsync_i   = 1'b0;
        hsync_i   = 1'b0;
        de_i      = 1'b0;
        color_a_i = '0;
        color_b_i = '0;
        rng_state = 32'd38533;
        cycles    = 0;
        slot      = 0;
        err_cnt   = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        #1 arst_n_i = 1'b0;                 // clean falling edge
        reset_state();
        opaque_ignores_b();
        blend_by_alpha();
        wrap_vs_clamp();
        sync_and_blanking();
        random_stream();
        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: video_blend.sv
/* three-stage pixel blender */

`timescale 1ns/1ps

module video_blend (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                vsync_i,
    input  logic                hsync_i,
    input  logic                de_i,
    input  video_pkg::argb_t    color_a_i,
    input  video_pkg::argb_t    color_b_i,
    output video_pkg::rgb_t     rgb_o,
    output logic                vsync_o,
    output logic                hsync_o,
    output logic                de_o
);

    import video_pkg::*;
    import blend_pkg::*;

    // decode -> execute
    rgb8_t  d_chan_a;
    rgb8_t  d_chan_b;
    alpha_t d_alpha_a;
    alpha_t d_alpha_b;
    logic   d_clamp;
    logic   d_vsync;
    logic   d_hsync;
    logic   d_de;

    // execute -> result
    prod3_t e_prod_a;
    prod3_t e_prod_b;
    logic   e_clamp;
    logic   e_vsync;
    logic   e_hsync;
    logic   e_de;

    blend_decode u_decode (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .vsync_i   (vsync_i),
        .hsync_i   (hsync_i),
        .de_i      (de_i),
        .color_a_i (color_a_i),
        .color_b_i (color_b_i),
        .chan_a_o  (d_chan_a),
        .chan_b_o  (d_chan_b),
        .alpha_a_o (d_alpha_a),
        .alpha_b_o (d_alpha_b),
        .clamp_o   (d_clamp),
        .vsync_o   (d_vsync),
        .hsync_o   (d_hsync),
        .de_o      (d_de)
    );

    blend_execute u_execute (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .chan_a_i  (d_chan_a),
        .chan_b_i  (d_chan_b),
        .alpha_a_i (d_alpha_a),
        .alpha_b_i (d_alpha_b),
        .clamp_i   (d_clamp),
        .vsync_i   (d_vsync),
        .hsync_i   (d_hsync),
        .de_i      (d_de),
        .prod_a_o  (e_prod_a),
        .prod_b_o  (e_prod_b),
        .clamp_o   (e_clamp),
        .vsync_o   (e_vsync),
        .hsync_o   (e_hsync),
        .de_o      (e_de)
    );

    blend_result u_result (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .prod_a_i  (e_prod_a),
        .prod_b_i  (e_prod_b),
        .clamp_i   (e_clamp),
        .vsync_i   (e_vsync),
        .hsync_i   (e_hsync),
        .de_i      (e_de),
        .rgb_o     (rgb_o),
        .vsync_o   (vsync_o),
        .hsync_o   (hsync_o),
        .de_o      (de_o)
    );

endmodule

// File: blend_result.sv
/* blend stage 3, sum and output */

`timescale 1ns/1ps

module blend_result (
    input  logic                clk,
    input  logic                arst_n_i,
    input  blend_pkg::prod3_t   prod_a_i,
    input  blend_pkg::prod3_t   prod_b_i,
    input  logic                clamp_i,
    input  logic                vsync_i,
    input  logic                hsync_i,
    input  logic                de_i,
    output video_pkg::rgb_t     rgb_o,
    output logic                vsync_o,
    output logic                hsync_o,
    output logic                de_o
);

    import video_pkg::*;
    import blend_pkg::*;

    rgb_t rgb;                              // next output pixel

    // one channel: shifted sum, then wrap or saturate
    function automatic nibble_t mix(prod_t pa, prod_t pb, logic clamp);
        chan_t sum;
        sum = chan_t'(pa >> PROD_SHIFT) + chan_t'(pb >> PROD_SHIFT);
        if (clamp && sum[CHAN_W-1]) begin
            return '1;                      // overflow pinned to full scale
        end
        return sum[CHAN_W-2 -: NIB_W];      // bits 6..3, carry dropped
    endfunction

    always_comb begin
        if (de_i) begin
            rgb.r = mix(prod_a_i.r, prod_b_i.r, clamp_i);
            rgb.g = mix(prod_a_i.g, prod_b_i.g, clamp_i);
            rgb.b = mix(prod_a_i.b, prod_b_i.b, clamp_i);
        end else begin
            rgb = '0;                       // black outside display
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rgb_o   <= '0;
            vsync_o <= 1'b0;
            hsync_o <= 1'b0;
            de_o    <= 1'b0;
        end else begin
            rgb_o   <= rgb;
            vsync_o <= vsync_i;             // sync delay 3, aligned with rgb_o
            hsync_o <= hsync_i;
            de_o    <= de_i;
        end
    end

endmodule

// File: blend_execute.sv
/* blend stage 2, multiply */

`timescale 1ns/1ps

module blend_execute (
    input  logic                clk,
    input  logic                arst_n_i,
    input  video_pkg::rgb8_t    chan_a_i,
    input  video_pkg::rgb8_t    chan_b_i,
    input  blend_pkg::alpha_t   alpha_a_i,
    input  blend_pkg::alpha_t   alpha_b_i,
    input  logic                clamp_i,
    input  logic                vsync_i,
    input  logic                hsync_i,
    input  logic                de_i,
    output blend_pkg::prod3_t   prod_a_o,
    output blend_pkg::prod3_t   prod_b_o,
    output logic                clamp_o,
    output logic                vsync_o,
    output logic                hsync_o,
    output logic                de_o
);

    import video_pkg::*;
    import blend_pkg::*;

    prod3_t prod_a;
    prod3_t prod_b;

    // unsigned 8x8, full 16-bit result
    function automatic prod_t mul(chan_t c, alpha_t w);
        return prod_t'(c) * prod_t'(w);
    endfunction

    always_comb begin
        prod_a.r = mul(chan_a_i.r, alpha_a_i);
        prod_a.g = mul(chan_a_i.g, alpha_a_i);
        prod_a.b = mul(chan_a_i.b, alpha_a_i);
        prod_b.r = mul(chan_b_i.r, alpha_b_i);
        prod_b.g = mul(chan_b_i.g, alpha_b_i);
        prod_b.b = mul(chan_b_i.b, alpha_b_i);
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            prod_a_o <= '0;
            prod_b_o <= '0;
            clamp_o  <= 1'b0;
            vsync_o  <= 1'b0;
            hsync_o  <= 1'b0;
            de_o     <= 1'b0;
        end else begin
            prod_a_o <= prod_a;
            prod_b_o <= prod_b;
            clamp_o  <= clamp_i;            // follows its pixel
            vsync_o  <= vsync_i;            // sync delay 2
            hsync_o  <= hsync_i;
            de_o     <= de_i;
        end
    end

endmodule

// File: blend_decode.sv
/* blend stage 1, decode */

`timescale 1ns/1ps

module blend_decode (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                vsync_i,
    input  logic                hsync_i,
    input  logic                de_i,
    input  video_pkg::argb_t    color_a_i,
    input  video_pkg::argb_t    color_b_i,
    output video_pkg::rgb8_t    chan_a_o,
    output video_pkg::rgb8_t    chan_b_o,
    output blend_pkg::alpha_t   alpha_a_o,
    output blend_pkg::alpha_t   alpha_b_o,
    output logic                clamp_o,
    output logic                vsync_o,
    output logic                hsync_o,
    output logic                de_o
);

    import video_pkg::*;
    import blend_pkg::*;

    blend_mode_e mode;                      // from pixel a alpha
    rgb8_t       chan_a;
    rgb8_t       chan_b;
    alpha_t      alpha_a;
    alpha_t      alpha_b;
    logic        clamp;

    // field repeated to fill a channel, 0xF -> 0xFF
    function automatic chan_t expand(nibble_t n);
        return {n, n};
    endfunction

    always_comb begin
        mode     = blend_mode_e'(color_a_i.a[NIB_W-1 -: 2]);
        chan_a.r = expand(color_a_i.r);
        chan_a.g = expand(color_a_i.g);
        chan_a.b = expand(color_a_i.b);
        chan_b.r = expand(color_b_i.r);
        chan_b.g = expand(color_b_i.g);
        chan_b.b = expand(color_b_i.b);
        alpha_a  = ALPHA_FULL;              // most modes keep a at full weight
        alpha_b  = expand(color_b_i.a);
        case (mode)
            MODE_BLEND: begin
                alpha_a = expand(~color_b_i.a); // inverse of b alpha
            end
            MODE_ADD_WRAP, MODE_ADD_CLAMP: begin
                alpha_a = ALPHA_FULL;
            end
            MODE_OPAQUE: begin
                alpha_b = ALPHA_NONE;       // b dropped
            end
            default: begin
                alpha_a = ALPHA_FULL;
            end
        endcase
        clamp = mode[1];                    // ADD_CLAMP and OPAQUE saturate
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            chan_a_o  <= '0;
            chan_b_o  <= '0;
            alpha_a_o <= '0;
            alpha_b_o <= '0;
            clamp_o   <= 1'b0;
            vsync_o   <= 1'b0;
            hsync_o   <= 1'b0;
            de_o      <= 1'b0;
        end else begin
            chan_a_o  <= chan_a;
            chan_b_o  <= chan_b;
            alpha_a_o <= alpha_a;
            alpha_b_o <= alpha_b;
            clamp_o   <= clamp;
            vsync_o   <= vsync_i;           // sync delay 1
            hsync_o   <= hsync_i;
            de_o      <= de_i;
        end
    end

endmodule

// File: blend_pkg.sv
/* blend modes and weights */

package blend_pkg;

    // mode carried in alpha bits 3..2 of pixel a
    typedef enum logic [1:0] {
        MODE_BLEND     = 2'd0,              // a * ~alpha_b + b * alpha_b
        MODE_ADD_WRAP  = 2'd1,              // a + b * alpha_b, wraps
        MODE_ADD_CLAMP = 2'd2,              // a + b * alpha_b, saturates
        MODE_OPAQUE    = 2'd3               // a only
    } blend_mode_e;

    typedef logic [video_pkg::CHAN_W-1:0]   alpha_t;    // 8-bit weight
    typedef logic [2*video_pkg::CHAN_W-1:0] prod_t;     // channel x alpha

    typedef struct packed {
        prod_t r;
        prod_t g;
        prod_t b;
    } prod3_t;

    localparam alpha_t ALPHA_FULL = 8'hFF;  // full weight
    localparam alpha_t ALPHA_NONE = '0;     // ignored
    localparam int     PROD_SHIFT = 9;      // keeps top 7 bits of each product

endpackage

// File: video_pkg.sv
/* video pixel formats */

package video_pkg;

    localparam int NIB_W  = 4;              // one argb field
    localparam int CHAN_W = 8;              // expanded channel

    typedef logic [NIB_W-1:0]  nibble_t;    // 4-bit colour or alpha
    typedef logic [CHAN_W-1:0] chan_t;      // 8-bit channel

    // 16-bit input pixel, alpha in the top nibble
    typedef struct packed {
        nibble_t a;                         // top two bits select mode on pixel a
        nibble_t r;
        nibble_t g;
        nibble_t b;
    } argb_t;

    // 12-bit output pixel
    typedef struct packed {
        nibble_t r;
        nibble_t g;
        nibble_t b;
    } rgb_t;

    typedef struct packed {
        chan_t r;                           // fields repeated twice
        chan_t g;
        chan_t b;
    } rgb8_t;

endpackage
